// ==== flist.f ====
logic/cp0RegPkg.sv
logic/excPkg.sv
logic/excReportIf.sv
logic/excArbiter.sv
logic/cp0Timer.sv
logic/cp0ExcState.sv
logic/cp0ReadMux.sv
logic/cp0Top.sv
verif/tbClock.sv
verif/cp0Tb.sv

// ==== logic/cp0ExcState.sv ====
// ==========================================================
// CP0 exception state
// Status, Cause, EPC and BadVAddr with exception entry,
// exception return and interrupt capture
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module cp0ExcState import cp0RegPkg::*, excPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 wrEn,
    input  regAddrT              wrAddr,
    input  logic [dataWidth-1:0] wrData,
    excReportIf.state            rep,
    input  logic [5:0]           hwInt,
    input  logic                 timerIrq,
    output logic [7:0]           statusIm,
    output logic                 statusExl,
    output logic                 statusIe,
    output logic                 causeBd,
    output logic [7:0]           causeIp,
    output excCodeT              causeExc,
    output logic [dataWidth-1:0] epc,
    output logic [dataWidth-1:0] badVAddr
);

    logic       statusWr;
    logic       causeWr;
    logic       epcWr;
    logic       excTaken;
    logic [5:0] irqLines;
    logic [5:0] ipHi;
    logic [1:0] ipLo;

    function automatic excCodeT codeOf(input excKindT kind);
        excCodeT code;
        case (kind)
            excAdelFetch, excAdelData: code = codeAdel;
            excAdes:                   code = codeAdes;
            excRi:                     code = codeRi;
            excSys:                    code = codeSys;
            excBp:                     code = codeBp;
            excTr:                     code = codeTr;
            excOv:                     code = codeOv;
            default:                   code = codeInt;
        endcase
        return code;
    endfunction

    assign statusWr = wrEn && (wrAddr == regStatus);
    assign causeWr  = wrEn && (wrAddr == regCause);
    assign epcWr    = wrEn && (wrAddr == regEpc);
    assign excTaken = (rep.kind != excNone) && (rep.kind != excEret);

    always_comb begin
        irqLines               = hwInt;
        irqLines[timerIrqLine] = hwInt[timerIrqLine] | timerIrq;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            statusIm  <= '0;
            statusIe  <= 1'b0;
            statusExl <= 1'b0;
        end else begin
            if (statusWr) begin
                statusIm <= wrData[statusImLsb +: 8];
                statusIe <= wrData[statusIeBit];
            end
            if (rep.kind == excEret)
                statusExl <= 1'b0;
            else if (excTaken)
                statusExl <= 1'b1;
            else if (statusWr)
                statusExl <= wrData[statusExlBit];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            causeBd  <= 1'b0;
            causeExc <= codeInt;
            ipHi     <= '0;
            ipLo     <= '0;
            epc      <= '0;
        end else begin
            ipHi <= irqLines; // Sampled every cycle
            if (causeWr)
                ipLo <= wrData[causeIpLsb +: 2];
            if (excTaken) begin
                causeExc <= codeOf(rep.kind);
                // Nested exceptions keep the original return point
                if (!statusExl) begin
                    causeBd <= rep.inDelaySlot;
                    epc     <= rep.inDelaySlot ? rep.pc - dataWidth'(4) : rep.pc;
                end
            end else if (epcWr) begin
                epc <= wrData;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            badVAddr <= '0;
        else if (rep.badAddrValid)
            badVAddr <= rep.badAddr;
    end

    assign causeIp = {ipHi, ipLo};

endmodule

`default_nettype wire

// ==== logic/cp0ReadMux.sv ====
// ==========================================================
// CP0 read port
// Packs the fields of the addressed register
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module cp0ReadMux import cp0RegPkg::*, excPkg::*; (
    input  regAddrT              rdAddr,
    input  logic [dataWidth-1:0] count,
    input  logic [dataWidth-1:0] compare,
    input  logic                 causeTi,
    input  logic [7:0]           statusIm,
    input  logic                 statusExl,
    input  logic                 statusIe,
    input  logic                 causeBd,
    input  logic [7:0]           causeIp,
    input  excCodeT              causeExc,
    input  logic [dataWidth-1:0] epc,
    input  logic [dataWidth-1:0] badVAddr,
    output logic [dataWidth-1:0] rdData
);

    logic [dataWidth-1:0] statusWord;
    logic [dataWidth-1:0] causeWord;

    always_comb begin
        statusWord                      = '0;
        statusWord[statusBevBit]        = 1'b1; // BEV hardwired
        statusWord[statusImLsb +: 8]    = statusIm;
        statusWord[statusExlBit]        = statusExl;
        statusWord[statusIeBit]         = statusIe;
        causeWord                       = '0;
        causeWord[causeBdBit]           = causeBd;
        causeWord[causeTiBit]           = causeTi;
        causeWord[causeIpLsb +: 8]      = causeIp;
        causeWord[causeExcLsb +: 5]     = causeExc;
    end

    always_comb begin
        case (rdAddr)
            regBadVAddr: rdData = badVAddr;
            regCount:    rdData = count;
            regCompare:  rdData = compare;
            regStatus:   rdData = statusWord;
            regCause:    rdData = causeWord;
            regEpc:      rdData = epc;
            default:     rdData = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/cp0RegPkg.sv ====
// ==========================================================
// CP0 register file definitions
// Addresses, field positions and reset values
// ==========================================================
`default_nettype none

package cp0RegPkg;

    localparam int dataWidth = 32;

    typedef logic [4:0] regAddrT;

    // Kept register addresses
    localparam regAddrT regBadVAddr = 5'd8;
    localparam regAddrT regCount    = 5'd9;
    localparam regAddrT regCompare  = 5'd11;
    localparam regAddrT regStatus   = 5'd12;
    localparam regAddrT regCause    = 5'd13;
    localparam regAddrT regEpc      = 5'd14;

    // Status fields
    localparam int statusBevBit = 22;
    localparam int statusImLsb  = 8;
    localparam int statusExlBit = 1;
    localparam int statusIeBit  = 0;

    // Cause fields
    localparam int causeBdBit  = 31;
    localparam int causeTiBit  = 30;
    localparam int causeIpLsb  = 8;
    localparam int causeExcLsb = 2;

    localparam int timerIrqLine = 5; // Timer joins IP7

    localparam logic [dataWidth-1:0] compareReset = '1;

endpackage

`default_nettype wire

// ==== logic/cp0Timer.sv ====
// ==========================================================
// CP0 Count/Compare timer
// Count advances at half the clock rate, match raises
// the timer interrupt and sets the TI pending bit
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module cp0Timer import cp0RegPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 wrEn,
    input  regAddrT              wrAddr,
    input  logic [dataWidth-1:0] wrData,
    output logic [dataWidth-1:0] count,
    output logic [dataWidth-1:0] compare,
    output logic                 timerIrq,
    output logic                 causeTi
);

    logic phase;
    logic countWr;
    logic compareWr;

    assign countWr   = wrEn && (wrAddr == regCount);
    assign compareWr = wrEn && (wrAddr == regCompare);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
            phase <= 1'b0;
        end else if (countWr) begin
            count <= wrData;
            phase <= 1'b0; // Restart the divide-by-two
        end else begin
            phase <= ~phase;
            if (phase)
                count <= count + dataWidth'(1);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            compare <= compareReset;
        else if (compareWr)
            compare <= wrData;
    end

    assign timerIrq = (count == compare);

    // Pending until software rewrites Compare
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            causeTi <= 1'b0;
        else if (compareWr)
            causeTi <= 1'b0;
        else if (timerIrq)
            causeTi <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== logic/cp0Top.sv ====
// ==========================================================
// CP0 coprocessor top level
// Exception arbiter, timer, exception state and read port
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module cp0Top import cp0RegPkg::*, excPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [5:0]           hwInt,
    input  regAddrT              rdAddr,
    output logic [dataWidth-1:0] rdData,
    input  logic                 wrEn,
    input  regAddrT              wrAddr,
    input  logic [dataWidth-1:0] wrData,
    input  excFlagsT             excFlags,
    input  logic [dataWidth-1:0] excPc,
    input  logic                 excInDelaySlot,
    input  logic [dataWidth-1:0] excAluOut,
    output logic [7:0]           statusIm,
    output logic                 statusExl,
    output logic                 statusIe,
    output logic [7:0]           causeIp,
    output logic [dataWidth-1:0] epc
);

    logic [dataWidth-1:0] count;
    logic [dataWidth-1:0] compare;
    logic                 timerIrq;
    logic                 causeTi;
    logic                 causeBd;
    excCodeT              causeExc;
    logic [dataWidth-1:0] badVAddr;

    excReportIf repBus ();

    excArbiter arb0 (
        .excFlags       (excFlags),
        .excPc          (excPc),
        .excInDelaySlot (excInDelaySlot),
        .excAluOut      (excAluOut),
        .rep            (repBus)
    );

    cp0Timer timer0 (
        .clk      (clk),
        .rstN     (rstN),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .count    (count),
        .compare  (compare),
        .timerIrq (timerIrq),
        .causeTi  (causeTi)
    );

    cp0ExcState state0 (
        .clk       (clk),
        .rstN      (rstN),
        .wrEn      (wrEn),
        .wrAddr    (wrAddr),
        .wrData    (wrData),
        .rep       (repBus),
        .hwInt     (hwInt),
        .timerIrq  (timerIrq),
        .statusIm  (statusIm),
        .statusExl (statusExl),
        .statusIe  (statusIe),
        .causeBd   (causeBd),
        .causeIp   (causeIp),
        .causeExc  (causeExc),
        .epc       (epc),
        .badVAddr  (badVAddr)
    );

    cp0ReadMux rdMux0 (
        .rdAddr    (rdAddr),
        .count     (count),
        .compare   (compare),
        .causeTi   (causeTi),
        .statusIm  (statusIm),
        .statusExl (statusExl),
        .statusIe  (statusIe),
        .causeBd   (causeBd),
        .causeIp   (causeIp),
        .causeExc  (causeExc),
        .epc       (epc),
        .badVAddr  (badVAddr),
        .rdData    (rdData)
    );

endmodule

`default_nettype wire

// ==== logic/excArbiter.sv ====
// ==========================================================
// Exception arbiter
// Picks the highest-priority writeback exception and
// the faulting address that goes with it
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module excArbiter import excPkg::*, cp0RegPkg::*; (
    input  excFlagsT             excFlags,
    input  logic [dataWidth-1:0] excPc,
    input  logic                 excInDelaySlot,
    input  logic [dataWidth-1:0] excAluOut,
    excReportIf.arbiter          rep
);

    excKindT kind;

    always_comb begin
        kind = excNone;
        if (excFlags.intr)           kind = excInt;
        else if (excFlags.adelFetch) kind = excAdelFetch;
        else if (excFlags.ri)        kind = excRi;
        else if (excFlags.sys)       kind = excSys;
        else if (excFlags.bp)        kind = excBp;
        else if (excFlags.eret)      kind = excEret;
        else if (excFlags.tr)        kind = excTr;
        else if (excFlags.ov)        kind = excOv;
        else if (excFlags.ades)      kind = excAdes;
        else if (excFlags.adelData)  kind = excAdelData;
    end

    always_comb begin
        rep.badAddrValid = 1'b0;
        rep.badAddr      = '0;
        if (kind == excAdelFetch) begin
            rep.badAddrValid = 1'b1;
            rep.badAddr      = excPc;     // Fetch fault reports the pc
        end else if (kind == excAdes || kind == excAdelData) begin
            rep.badAddrValid = 1'b1;
            rep.badAddr      = excAluOut; // Data fault reports the address
        end
    end

    assign rep.kind        = kind;
    assign rep.pc          = excPc;
    assign rep.inDelaySlot = excInDelaySlot;

endmodule

`default_nettype wire

// ==== logic/excPkg.sv ====
// ==========================================================
// Exception definitions
// Exception kinds, writeback flags and cause codes
// ==========================================================
`default_nettype none

package excPkg;

    // Listed in arbitration order after excNone
    typedef enum logic [3:0] {
        excNone,
        excInt,
        excAdelFetch,
        excRi,
        excSys,
        excBp,
        excEret,
        excTr,
        excOv,
        excAdes,
        excAdelData
    } excKindT;

    typedef struct packed {
        logic intr;
        logic adelFetch;
        logic ri;
        logic sys;
        logic bp;
        logic eret;
        logic tr;
        logic ov;
        logic ades;
        logic adelData;
    } excFlagsT;

    typedef logic [4:0] excCodeT;

    localparam excCodeT codeInt  = 5'd0;
    localparam excCodeT codeAdel = 5'd4;
    localparam excCodeT codeAdes = 5'd5;
    localparam excCodeT codeSys  = 5'd8;
    localparam excCodeT codeBp   = 5'd9;
    localparam excCodeT codeRi   = 5'd10;
    localparam excCodeT codeOv   = 5'd12;
    localparam excCodeT codeTr   = 5'd13;

endpackage

`default_nettype wire

// ==== logic/excReportIf.sv ====
// ==========================================================
// Exception report bus
// Carries the chosen exception to the state registers
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

interface excReportIf import excPkg::*, cp0RegPkg::*; ();

    excKindT              kind;
    logic [dataWidth-1:0] pc;
    logic                 inDelaySlot;
    logic [dataWidth-1:0] badAddr;
    logic                 badAddrValid;

    modport arbiter (output kind, pc, inDelaySlot, badAddr, badAddrValid);
    modport state   (input kind, pc, inDelaySlot, badAddr, badAddrValid);

endinterface

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the CP0 testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cp0Tb -f flist.f -o cp0Sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cp0Sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== verif/cp0Tb.sv ====
// ==========================================================
// CP0 testbench
// Drives writes, exceptions and interrupts into the DUT and
// checks reads and outputs against a reference model
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module cp0Tb import cp0RegPkg::*, excPkg::*; ();

    logic        clk;
    logic        rstN;
    logic [5:0]  hwInt;
    regAddrT     rdAddr;
    logic [31:0] rdData;
    logic        wrEn;
    regAddrT     wrAddr;
    logic [31:0] wrData;
    excFlagsT    excFlags;
    logic [31:0] excPc;
    logic        excInDelaySlot;
    logic [31:0] excAluOut;
    logic [7:0]  statusIm;
    logic        statusExl;
    logic        statusIe;
    logic [7:0]  causeIp;
    logic [31:0] epc;

    // Reference model
    logic [31:0] mBase;
    logic [31:0] mEdges;   // Edges since reset or Count write
    logic [31:0] mCount;
    logic [31:0] mCompare;
    logic [31:0] mEpc;
    logic [31:0] mBadV;
    logic [31:0] expRd;
    logic        mTi;
    logic        mIe;
    logic        mExl;
    logic        mBd;
    logic        timerHit;
    logic [7:0]  mIm;
    logic [5:0]  mIpHi;
    logic [1:0]  mIpLo;
    excCodeT     mExc;
    int          topBit;
    int          errCount = 0;
    int          timeoutCount = 0;
    integer      seed;

    tbClock clkGen (.clk(clk));

    cp0Top dut0 (.*);

    // Flag vector runs lowest to highest priority, so the last set bit wins
    function automatic int firstFlag(input logic [9:0] f);
        int top;
        top = -1;
        for (int i = 0; i < 10; i++)
            if (f[i])
                top = i;
        return top;
    endfunction

    function automatic excCodeT codeForBit(input int b);
        case (b)
            9:       return codeInt;
            8:       return codeAdel;
            7:       return codeRi;
            6:       return codeSys;
            5:       return codeBp;
            3:       return codeTr;
            2:       return codeOv;
            1:       return codeAdes;
            default: return codeAdel;
        endcase
    endfunction

    assign mCount   = mBase + (mEdges >> 1);
    assign timerHit = (mCount == mCompare);

    always_comb topBit = firstFlag(excFlags);

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mBase    <= '0;
            mEdges   <= '0;
            mCompare <= 32'hFFFF_FFFF;
            mTi      <= 1'b0;
            mIm      <= '0;
            mIe      <= 1'b0;
            mExl     <= 1'b0;
            mBd      <= 1'b0;
            mIpHi    <= '0;
            mIpLo    <= '0;
            mExc     <= codeInt;
            mEpc     <= '0;
            mBadV    <= '0;
        end else begin
            mEdges <= mEdges + 32'd1;
            if (wrEn && wrAddr == regCount) begin
                mBase  <= wrData;
                mEdges <= '0;
            end
            if (wrEn && wrAddr == regCompare) begin
                mCompare <= wrData;
                mTi      <= 1'b0;
            end else if (timerHit) begin
                mTi <= 1'b1;
            end
            if (wrEn && wrAddr == regStatus) begin
                mIm <= wrData[15:8];
                mIe <= wrData[0];
            end
            if (topBit == 4)
                mExl <= 1'b0; // Eret
            else if (topBit >= 0)
                mExl <= 1'b1;
            else if (wrEn && wrAddr == regStatus)
                mExl <= wrData[1];
            if (wrEn && wrAddr == regCause)
                mIpLo <= wrData[9:8];
            mIpHi <= hwInt | {timerHit, 5'b0}; // Timer on IP7
            if (topBit >= 0 && topBit != 4) begin
                mExc <= codeForBit(topBit);
                if (!mExl) begin
                    mBd  <= excInDelaySlot;
                    mEpc <= excInDelaySlot ? excPc - 32'd4 : excPc;
                end
            end else if (wrEn && wrAddr == regEpc) begin
                mEpc <= wrData;
            end
            if (topBit == 8)
                mBadV <= excPc;
            else if (topBit == 1 || topBit == 0)
                mBadV <= excAluOut;
        end
    end

    always_comb begin
        case (rdAddr)
            regBadVAddr: expRd = mBadV;
            regCount:    expRd = mCount;
            regCompare:  expRd = mCompare;
            regStatus:   expRd = {9'b0, 1'b1, 6'b0, mIm, 6'b0, mExl, mIe};
            regCause:    expRd = {mBd, mTi, 14'b0, mIpHi, mIpLo, 1'b0, mExc, 2'b0};
            regEpc:      expRd = mEpc;
            default:     expRd = '0;
        endcase
    end

    task automatic reportValue(input string name, input logic [31:0] expv,
                               input logic [31:0] act);
        errCount++;
        $display("ERR %0t %s expected %h actual %h", $time, name, expv, act);
    endtask

    assert property (@(negedge clk) disable iff (!rstN) rdData == expRd)
        else reportValue("rdData", expRd, rdData);
    assert property (@(negedge clk) disable iff (!rstN) epc == mEpc)
        else reportValue("epc", mEpc, epc);
    assert property (@(negedge clk) disable iff (!rstN) causeIp == {mIpHi, mIpLo})
        else reportValue("causeIp", 32'({mIpHi, mIpLo}), 32'(causeIp));
    assert property (@(negedge clk) disable iff (!rstN) statusIm == mIm)
        else reportValue("statusIm", 32'(mIm), 32'(statusIm));
    assert property (@(negedge clk) disable iff (!rstN) statusExl == mExl)
        else reportValue("statusExl", 32'(mExl), 32'(statusExl));
    assert property (@(negedge clk) disable iff (!rstN) statusIe == mIe)
        else reportValue("statusIe", 32'(mIe), 32'(statusIe));

    task automatic writeReg(input regAddrT a, input logic [31:0] d);
        @(posedge clk);
        wrEn   <= 1'b1;
        wrAddr <= a;
        wrData <= d;
        @(posedge clk);
        wrEn <= 1'b0;
    endtask

    task automatic readAll();
        regAddrT addrs[7] = '{regBadVAddr, regCount, regCompare, regStatus,
                              regCause, regEpc, 5'd3};
        for (int i = 0; i < 7; i++) begin
            @(posedge clk);
            rdAddr <= addrs[i];
        end
    endtask

    task automatic raiseExc(input excFlagsT f, input logic [31:0] pc, input logic ds,
                            input logic [31:0] alu);
        @(posedge clk);
        excFlags       <= f;
        excPc          <= pc;
        excInDelaySlot <= ds;
        excAluOut      <= alu;
        @(posedge clk);
        excFlags <= '0;
    endtask

    task automatic waitTimerIrq(input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!causeIp[7] && n < limit);
        if (!causeIp[7]) begin
            timeoutCount++;
            $display("Timeout: causeIp bit 7 stayed low for %0d cycles", limit);
        end
    endtask

    initial begin
        excFlagsT    f;
        logic [31:0] r;
        logic [31:0] v;
        seed           = 95852;
        rstN           = 1'b0;
        hwInt          = '0;
        rdAddr         = regStatus;
        wrEn           = 1'b0;
        wrAddr         = '0;
        wrData         = '0;
        excFlags       = '0;
        excPc          = '0;
        excInDelaySlot = 1'b0;
        excAluOut      = '0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        readAll();

        for (int i = 0; i < 12; i++) begin
            r = $random(seed);
            case (i % 4)
                0:       writeReg(regStatus, r);
                1:       writeReg(regEpc, r);
                2:       writeReg(regCompare, r);
                default: writeReg(regCause, r);
            endcase
            readAll();
        end

        // Count load followed by five ticks
        v = $random(seed);
        writeReg(regCount, v);
        rdAddr <= regCount;
        repeat (10) @(posedge clk);
        @(negedge clk);
        assert (rdData == v + 32'd5) else reportValue("count", v + 32'd5, rdData);

        writeReg(regCount, 32'h0000_0100);
        writeReg(regCompare, 32'h0000_0106);
        waitTimerIrq(40);
        @(posedge clk);
        rdAddr <= regCause;
        writeReg(regCompare, 32'hFFFF_FFF0); // Clears TI
        readAll();

        writeReg(regStatus, 32'h0000_0000);
        rdAddr <= regCause;
        f = '0;
        f.sys = 1'b1;
        raiseExc(f, 32'h8000_1000, 1'b0, '0);
        f = '0;
        f.bp = 1'b1;
        raiseExc(f, 32'h8000_2000, 1'b0, '0); // Nested exception keeps EPC
        f = '0;
        f.eret = 1'b1;
        raiseExc(f, '0, 1'b0, '0);
        f = '0;
        f.sys = 1'b1;
        raiseExc(f, 32'h8000_3004, 1'b1, '0);
        readAll();

        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            v = $random(seed);
            f = r[9:0] >> r[13:10]; // Spread over priority levels
            raiseExc(f, v, r[20], $random(seed));
            readAll();
        end

        // Every priority level and both BadVAddr sources
        f = '1;
        raiseExc(f, 32'h8000_4000, 1'b0, 32'h0000_1357);
        readAll();
        f = '0;
        f.adelFetch = 1'b1;
        f.ov        = 1'b1;
        raiseExc(f, 32'hBFC0_0101, 1'b0, 32'h0000_2468);
        readAll();
        f = '0;
        f.ades = 1'b1;
        raiseExc(f, 32'h8000_5000, 1'b0, 32'h1000_0002);
        readAll();
        f = '0;
        f.adelData = 1'b1;
        raiseExc(f, 32'h8000_6000, 1'b0, 32'h2000_0001);
        readAll();

        rdAddr <= regCause;
        for (int i = 0; i < 10; i++) begin
            r = $random(seed);
            @(posedge clk);
            hwInt <= r[5:0];
        end
        @(posedge clk);
        hwInt <= '0;
        repeat (2) @(posedge clk);
        @(negedge clk);

        $display("Errors: %0d value mismatches, %0d timeouts", errCount, timeoutCount);
        if (errCount == 0 && timeoutCount == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tbClock.sv ====
// ==========================================================
// Testbench clock
// Free-running 100 ns clock for the CP0 testbench
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk
);

    initial clk = 1'b0;

    always #50 clk = ~clk; // Half period

endmodule

`default_nettype wire
